// File: common/fifoCfgPkg.sv
`default_nettype none

package fifoCfgPkg;

    // Data word width
    localparam int DefaultWidth = 16;

    // Address bits, 32 entries
    localparam int DefaultDepthLog2 = 5;

    // Retiming depth on the read address path to the memory
    localparam int DefaultReadAddrStages = 1;

    // Retiming depth on the write strobe, address and data
    localparam int DefaultWriteAddrStages = 2;

    // 1 for distributed RAM, 0 for block RAM with two output registers
    localparam int DefaultIsMlab = 1;

    // Cycles from an accepted read to the word at the output.
    // The address register adds one cycle, block RAM adds two more
    function automatic int readLatency(input int readAddrStages, input int isMlab);
        int extra;
        extra = (isMlab != 0) ? 1 : 3;
        return readAddrStages + extra;
    endfunction

endpackage

`default_nettype wire

// File: common/eccPkg.sv
`default_nettype none

package eccPkg;

    // Check bits stored next to every data word
    localparam int ParityWidth = 1;

    // Widest data word the check functions take, narrower words are zero extended
    localparam int MaxDataWidth = 512;

    // Even parity over the data word
    function automatic logic [ParityWidth-1:0] parityOf(
        input logic [MaxDataWidth-1:0] data
    );
        logic [ParityWidth-1:0] check;
        check = '0;
        check[0] = ^data;
        return check;
    endfunction

    // High when the stored check bits do not match the data read back
    function automatic logic parityFails(
        input logic [MaxDataWidth-1:0] data,
        input logic [ParityWidth-1:0] check
    );
        logic [ParityWidth-1:0] expected;
        expected = parityOf(data);
        return expected != check;
    endfunction

endpackage

`default_nettype wire

// File: common/memReadIf.sv
`timescale 1ns/1ns
`default_nettype none

interface memReadIf #(
    parameter int width = fifoCfgPkg::DefaultWidth,
    parameter int depthLog2 = fifoCfgPkg::DefaultDepthLog2
);
    // Toward the memory
    logic readAddressStall;
    logic [depthLog2-1:0] readAddr;

    // Back from the memory
    logic [width-1:0] dataOut;
    logic eccStatus;

    modport controller (
        output readAddressStall,
        output readAddr,
        input dataOut,
        input eccStatus
    );

    modport memory (
        input readAddressStall,
        input readAddr,
        output dataOut,
        output eccStatus
    );

endinterface

`default_nettype wire

// File: fifo/delayPipe.sv
`timescale 1ns/1ns
`default_nettype none

module delayPipe #(
    parameter int cycles = 1,
    parameter int width = 1
) (
    input wire logic rdclk,
    input wire logic [width-1:0] din,
    output logic [width-1:0] dout
);

    generate
        if (cycles == 0) begin : gWire
            // Zero stages, plain connection
            assign dout = din;
        end else begin : gRegs
            logic [width-1:0] stages [cycles];

            // Shift register, stage 0 takes the input
            always_ff @(posedge rdclk) begin
                stages[0] <= din;
                for (int i = 1; i < cycles; i++) begin
                    stages[i] <= stages[i-1];
                end
            end

            assign dout = stages[cycles-1];
        end
    endgenerate

endmodule

`default_nettype wire

// File: fifo/fifoController.sv
`timescale 1ns/1ns
`default_nettype none

module fifoController #(
    parameter int depthLog2 = fifoCfgPkg::DefaultDepthLog2,
    parameter int readAddrStages = fifoCfgPkg::DefaultReadAddrStages,
    parameter int writeAddrStages = fifoCfgPkg::DefaultWriteAddrStages
) (
    input wire logic rdclk,
    input wire logic rdrst,
    input wire logic writeEnable,
    input wire logic readRequest,
    output logic [depthLog2-1:0] usedw,
    output logic empty,
    output logic isReading,
    output logic [depthLog2-1:0] writeAddr,
    memReadIf.controller memRd
);

    logic [depthLog2-1:0] nextWriteAddr;
    logic [depthLog2-1:0] nextReadAddr;
    logic [depthLog2-1:0] readsValidUpTo;
    logic [depthLog2-1:0] writesValidUpTo;

    assign nextWriteAddr = writeAddr + 1'b1;

    // Write pointer reaches the read side only after the data is in the memory
    delayPipe #(
        .cycles(writeAddrStages + 1),
        .width(depthLog2)
    ) writePtrPipe (
        .rdclk(rdclk),
        .din(nextWriteAddr),
        .dout(readsValidUpTo)
    );

    // Slots are freed once the memory has taken the read address
    delayPipe #(
        .cycles(readAddrStages),
        .width(depthLog2)
    ) readPtrPipe (
        .rdclk(rdclk),
        .din(nextReadAddr),
        .dout(writesValidUpTo)
    );

    // Both pointers carry the same +1 offset
    assign empty = readsValidUpTo == nextReadAddr;
    assign usedw = nextWriteAddr - writesValidUpTo;
    assign isReading = readRequest && !empty;

    // Address register in the memory only loads on an accepted read
    assign memRd.readAddressStall = !isReading;
    assign memRd.readAddr = nextReadAddr - 1'b1;

    always_ff @(posedge rdclk) begin
        if (rdrst) begin
            writeAddr <= '0;
            nextReadAddr <= depthLog2'(1);
        end else begin
            if (writeEnable) begin
                writeAddr <= nextWriteAddr;
            end
            if (isReading) begin
                nextReadAddr <= nextReadAddr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: fifo/fifoMemory.sv
`timescale 1ns/1ns
`default_nettype none

module fifoMemory #(
    parameter int width = fifoCfgPkg::DefaultWidth,
    parameter int depthLog2 = fifoCfgPkg::DefaultDepthLog2,
    parameter int isMlab = fifoCfgPkg::DefaultIsMlab
) (
    input wire logic rdclk,
    input wire logic rdrst,
    input wire logic writeEnable,
    input wire logic [depthLog2-1:0] writeAddr,
    input wire logic [width-1:0] dataIn,
    memReadIf.memory memRd
);

    // Stored word is {check bits, data}
    localparam int WordWidth = width + eccPkg::ParityWidth;

    logic [WordWidth-1:0] storage [2**depthLog2];
    logic [eccPkg::MaxDataWidth-1:0] writeWide;
    logic [eccPkg::MaxDataWidth-1:0] readWide;
    logic [depthLog2-1:0] readAddrReg;
    logic addrLoaded;
    logic [WordWidth-1:0] outWord;
    logic outLoaded;

    always_comb begin
        writeWide = '0;
        writeWide[width-1:0] = dataIn;
    end

    always_ff @(posedge rdclk) begin
        if (writeEnable) begin
            storage[writeAddr] <= {eccPkg::parityOf(writeWide), dataIn};
        end
    end

    // Read address register, holds while stalled
    always_ff @(posedge rdclk) begin
        if (rdrst) begin
            readAddrReg <= '0;
            addrLoaded <= 1'b0;
        end else begin
            addrLoaded <= !memRd.readAddressStall;
            if (!memRd.readAddressStall) begin
                readAddrReg <= memRd.readAddr;
            end
        end
    end

    generate
        if (isMlab != 0) begin : gMlab
            // Distributed RAM, combinational read
            assign outWord = storage[readAddrReg];
            assign outLoaded = addrLoaded;
        end else begin : gBlock
            logic [WordWidth-1:0] wordQ1;
            logic [WordWidth-1:0] wordQ2;
            logic loadedQ1;
            logic loadedQ2;

            always_ff @(posedge rdclk) begin
                wordQ1 <= storage[readAddrReg];
                wordQ2 <= wordQ1;
            end

            always_ff @(posedge rdclk) begin
                if (rdrst) begin
                    loadedQ1 <= 1'b0;
                    loadedQ2 <= 1'b0;
                end else begin
                    loadedQ1 <= addrLoaded;
                    loadedQ2 <= loadedQ1;
                end
            end

            assign outWord = wordQ2;
            assign outLoaded = loadedQ2;
        end
    endgenerate

    always_comb begin
        readWide = '0;
        readWide[width-1:0] = outWord[width-1:0];
    end

    // Parity is only judged on words that were really read
    assign memRd.dataOut = outWord[width-1:0];
    assign memRd.eccStatus = outLoaded
        && eccPkg::parityFails(readWide, outWord[WordWidth-1:width]);

endmodule

`default_nettype wire

// File: hw/fastFifo.sv
`timescale 1ns/1ns
`default_nettype none

module fastFifo #(
    parameter int width = fifoCfgPkg::DefaultWidth,
    parameter int depthLog2 = fifoCfgPkg::DefaultDepthLog2,
    parameter int isMlab = fifoCfgPkg::DefaultIsMlab,
    parameter int readAddrStages = fifoCfgPkg::DefaultReadAddrStages,
    parameter int writeAddrStages = fifoCfgPkg::DefaultWriteAddrStages
) (
    input wire logic rdclk,
    input wire logic rdrst,

    // Write side
    input wire logic writeEnable,
    input wire logic [width-1:0] dataIn,
    output logic [depthLog2-1:0] usedw,

    // Read side
    input wire logic readRequest,
    output logic [width-1:0] dataOut,
    output logic dataOutValid,
    output logic empty,
    output logic eccStatus
);

    localparam int ReadLatency = fifoCfgPkg::readLatency(readAddrStages, isMlab);

    logic isReading;
    logic [depthLog2-1:0] writeAddr;
    logic [depthLog2:0] writePortD;
    logic [width-1:0] dataInD;
    logic [depthLog2:0] readPortD;

    // Read port before and after the address retiming
    memReadIf #(.width(width), .depthLog2(depthLog2)) ctrlRd ();
    memReadIf #(.width(width), .depthLog2(depthLog2)) memRd ();

    fifoController #(
        .depthLog2(depthLog2),
        .readAddrStages(readAddrStages),
        .writeAddrStages(writeAddrStages)
    ) controller (
        .rdclk(rdclk),
        .rdrst(rdrst),
        .writeEnable(writeEnable),
        .readRequest(readRequest),
        .usedw(usedw),
        .empty(empty),
        .isReading(isReading),
        .writeAddr(writeAddr),
        .memRd(ctrlRd)
    );

    // Write strobe and address travel together
    delayPipe #(.cycles(writeAddrStages), .width(depthLog2 + 1)) writePipe (
        .rdclk(rdclk),
        .din({writeEnable, writeAddr}),
        .dout(writePortD)
    );

    delayPipe #(.cycles(writeAddrStages), .width(width)) writeDataPipe (
        .rdclk(rdclk),
        .din(dataIn),
        .dout(dataInD)
    );

    delayPipe #(.cycles(readAddrStages), .width(depthLog2 + 1)) readAddrPipe (
        .rdclk(rdclk),
        .din({ctrlRd.readAddressStall, ctrlRd.readAddr}),
        .dout(readPortD)
    );

    assign memRd.readAddressStall = readPortD[depthLog2];
    assign memRd.readAddr = readPortD[depthLog2-1:0];

    fifoMemory #(
        .width(width),
        .depthLog2(depthLog2),
        .isMlab(isMlab)
    ) memory (
        .rdclk(rdclk),
        .rdrst(rdrst),
        .writeEnable(writePortD[depthLog2]),
        .writeAddr(writePortD[depthLog2-1:0]),
        .dataIn(dataInD),
        .memRd(memRd)
    );

    // Returned word seen from the controller side of the port
    assign ctrlRd.dataOut = memRd.dataOut;
    assign ctrlRd.eccStatus = memRd.eccStatus;
    assign dataOut = ctrlRd.dataOut;
    assign eccStatus = ctrlRd.eccStatus;

    // Valid follows the accepted read by the full read latency
    delayPipe #(.cycles(ReadLatency), .width(1)) validPipe (
        .rdclk(rdclk),
        .din(isReading),
        .dout(dataOutValid)
    );

endmodule

`default_nettype wire

// File: tests/clockGen.sv
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
    parameter int halfPeriod = 50,
    parameter int resetCycles = 10
) (
    output logic rdclk,
    output logic rdrst
);

    initial begin
        rdclk = 1'b0;
        forever #(halfPeriod) rdclk = ~rdclk;
    end

    // Reset drops on a rising edge, like any other stimulus
    initial begin
        rdrst = 1'b1;
        repeat (resetCycles) @(posedge rdclk);
        rdrst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/fastFifo_assert.sv
`timescale 1ns/1ns
`default_nettype none

module fastFifo_assert #(
    parameter int readAddrStages = fifoCfgPkg::DefaultReadAddrStages,
    parameter int isMlab = fifoCfgPkg::DefaultIsMlab
) (
    input wire logic rdclk,
    input wire logic rdrst,
    input wire logic readRequest,
    input wire logic empty,
    input wire logic dataOutValid,
    input wire logic eccStatus
);

    localparam int ReadLatency = fifoCfgPkg::readLatency(readAddrStages, isMlab);

    logic accepted;
    logic [ReadLatency-1:0] acceptHist;

    assign accepted = readRequest && !empty;

    // Oldest bit lines up with the valid strobe of that read
    always_ff @(posedge rdclk) begin
        if (rdrst) begin
            acceptHist <= '0;
        end else begin
            acceptHist <= (acceptHist << 1) | ReadLatency'(accepted);
        end
    end

    emptyAfterReset: assert property (@(posedge rdclk) $fell(rdrst) |-> empty)
        else $error("FIFO not empty in the first cycle after reset");

    readGivesValid: assert property (@(posedge rdclk) disable iff (rdrst)
        acceptHist[ReadLatency-1] |-> dataOutValid)
        else $error("accepted read without dataOutValid at the read latency");

    validNeedsRead: assert property (@(posedge rdclk) disable iff (rdrst)
        dataOutValid |-> acceptHist[ReadLatency-1])
        else $error("dataOutValid without an accepted read at the read latency");

    noParityError: assert property (@(posedge rdclk) disable iff (rdrst)
        dataOutValid |-> !eccStatus)
        else $error("eccStatus high on a valid word");

endmodule

`default_nettype wire

// File: tests/fastFifoTb.sv
`timescale 1ns/1ns
`default_nettype none

module fastFifoTb;

    localparam int Width = fifoCfgPkg::DefaultWidth;
    localparam int DepthLog2 = fifoCfgPkg::DefaultDepthLog2;
    localparam int ReadLatency = fifoCfgPkg::readLatency(
        fifoCfgPkg::DefaultReadAddrStages, fifoCfgPkg::DefaultIsMlab);
    // Writes stop once usedw reaches this
    localparam int WriteLimit = 2**DepthLog2
        - (fifoCfgPkg::DefaultWriteAddrStages + fifoCfgPkg::DefaultReadAddrStages + 4);
    localparam int Timeout = 200;

    logic rdclk;
    logic rdrst;
    logic writeEnable;
    logic [Width-1:0] dataIn;
    logic readRequest;
    logic [DepthLog2-1:0] usedw;
    logic [Width-1:0] dataOut;
    logic dataOutValid;
    logic empty;
    logic eccStatus;

    logic [Width-1:0] expectQ [$];
    int acceptQ [$];
    int cycleCount = 0;
    int writesSeen = 0;
    int validsSeen = 0;
    int wordsChecked = 0;
    int runCount = 0;
    logic validLast = 1'b0;
    int compareErrors = 0;
    int stimErrors = 0;

    clockGen clocks (.rdclk(rdclk), .rdrst(rdrst));

    fastFifo dut (
        .rdclk(rdclk),
        .rdrst(rdrst),
        .writeEnable(writeEnable),
        .dataIn(dataIn),
        .usedw(usedw),
        .readRequest(readRequest),
        .dataOut(dataOut),
        .dataOutValid(dataOutValid),
        .empty(empty),
        .eccStatus(eccStatus)
    );

    bind fastFifo fastFifo_assert #(
        .readAddrStages(readAddrStages),
        .isMlab(isMlab)
    ) portChecks (
        .rdclk(rdclk),
        .rdrst(rdrst),
        .readRequest(readRequest),
        .empty(empty),
        .dataOutValid(dataOutValid),
        .eccStatus(eccStatus)
    );

    always @(posedge rdclk) begin
        cycleCount <= cycleCount + 1;
    end

    // Oldest word still held by the queue model
    function automatic logic [Width-1:0] expectedWord();
        return expectQ[0];
    endfunction

    task automatic compareOutput();
        logic [Width-1:0] expected;
        int acceptedAt;
        validsSeen++;
        if (expectQ.size() == 0 || acceptQ.size() == 0) begin
            $display("dataOutValid high at %0t with no word expected", $time);
            compareErrors++;
            return;
        end
        expected = expectedWord();
        acceptedAt = acceptQ.pop_front();
        void'(expectQ.pop_front());
        assert (dataOut === expected) else begin
            $display("ERR %0t dataOut expected %h got %h", $time, expected, dataOut);
            compareErrors++;
        end
        assert (eccStatus === 1'b0) else begin
            $display("ERR %0t eccStatus expected 0 got %b", $time, eccStatus);
            compareErrors++;
        end
        assert (cycleCount - acceptedAt == ReadLatency) else begin
            $display("ERR %0t dataOutValid latency expected %0d got %0d", $time,
                ReadLatency, cycleCount - acceptedAt);
            compareErrors++;
        end
        wordsChecked++;
    endtask

    // Outputs and strobes are sampled midway through the cycle
    always @(negedge rdclk) begin
        if (!rdrst) begin
            if (writeEnable) begin
                expectQ.push_back(dataIn);
                writesSeen++;
            end
            if (readRequest && !empty) begin
                acceptQ.push_back(cycleCount);
            end
            if (dataOutValid) begin
                if (!validLast) begin
                    runCount++;
                end
                compareOutput();
            end
            validLast = dataOutValid;
            assert (int'(usedw) <= writesSeen - validsSeen) else begin
                $display("ERR %0t usedw expected at most %0d got %0d", $time,
                    writesSeen - validsSeen, usedw);
                compareErrors++;
            end
        end
    end

    task automatic driveCycle(input logic doWrite, input logic doRead);
        logic [Width-1:0] word;
        word = Width'($urandom);
        @(posedge rdclk);
        writeEnable <= doWrite;
        dataIn <= word;
        readRequest <= doRead;
    endtask

    task automatic waitResetRelease();
        for (int i = 0; i < Timeout; i++) begin
            @(negedge rdclk);
            if (rdrst === 1'b0) return;
        end
        $display("reset was never released");
        stimErrors++;
    endtask

    task automatic waitEmptyFall(input string what);
        for (int i = 0; i < Timeout; i++) begin
            @(negedge rdclk);
            if (empty === 1'b0) return;
        end
        $display("empty never fell while %s", what);
        stimErrors++;
    endtask

    task automatic waitWords(input int target, input string what);
        for (int i = 0; i < Timeout; i++) begin
            @(negedge rdclk);
            if (validsSeen >= target) return;
        end
        $display("words missing at the output after %s", what);
        stimErrors++;
    endtask

    task automatic waitDrained(input string what);
        for (int i = 0; i < Timeout; i++) begin
            @(negedge rdclk);
            if (empty === 1'b1 && usedw === '0) return;
        end
        $display("FIFO did not return to empty with usedw 0 %s", what);
        stimErrors++;
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        $display("%s: %0d errors", name, stimErrors + compareErrors - errorsBefore);
    endtask

    initial begin
        int startErrors;
        int runsBefore;
        int i;
        logic doWrite;
        logic doRead;
        logic lastWrite;
        writeEnable = 1'b0;
        dataIn = '0;
        readRequest = 1'b0;
        void'($urandom(32'h2de4_dcf3));
        waitResetRelease();

        startErrors = stimErrors + compareErrors;
        assert (empty === 1'b1) else begin
            $display("ERR %0t empty expected 1 got %b", $time, empty);
            stimErrors++;
        end
        assert (usedw === '0) else begin
            $display("ERR %0t usedw expected 0 got %0d", $time, usedw);
            stimErrors++;
        end
        assert (dataOutValid === 1'b0) else begin
            $display("ERR %0t dataOutValid expected 0 got %b", $time, dataOutValid);
            stimErrors++;
        end
        for (i = 0; i < 20 + ReadLatency; i++) begin
            driveCycle(1'b0, i < 20);
            @(negedge rdclk);
            assert (dataOutValid === 1'b0) else begin
                $display("ERR %0t dataOutValid expected 0 got %b", $time, dataOutValid);
                stimErrors++;
            end
        end
        reportTest("reset state and reads while empty", startErrors);

        startErrors = stimErrors + compareErrors;
        driveCycle(1'b1, 1'b0);
        driveCycle(1'b0, 1'b0);
        waitEmptyFall("waiting for the single word");
        driveCycle(1'b0, 1'b1);
        driveCycle(1'b0, 1'b0);
        waitWords(writesSeen, "the single read");
        reportTest("single write and read", startErrors);

        startErrors = stimErrors + compareErrors;
        runsBefore = runCount;
        for (i = 0; i < WriteLimit; i++) begin
            driveCycle(1'b1, 1'b0);
        end
        for (i = 0; i < WriteLimit; i++) begin
            driveCycle(1'b0, 1'b1);
        end
        driveCycle(1'b0, 1'b0);
        waitWords(writesSeen, "the burst");
        assert (runCount == runsBefore + 1) else begin
            $display("burst words did not come out one per cycle");
            stimErrors++;
        end
        reportTest("burst to the write limit", startErrors);

        startErrors = stimErrors + compareErrors;
        lastWrite = 1'b0;
        for (i = 0; i < 400; i++) begin
            // The write driven in the current cycle is not counted yet
            doWrite = ($urandom % 5 < 3)
                && (writesSeen + int'(lastWrite) - validsSeen < WriteLimit);
            doRead = ($urandom % 2) == 0;
            driveCycle(doWrite, doRead);
            lastWrite = doWrite;
        end
        reportTest("random writes and reads", startErrors);

        startErrors = stimErrors + compareErrors;
        i = 0;
        while (validsSeen < writesSeen && i < Timeout) begin
            driveCycle(1'b0, 1'b1);
            i++;
        end
        driveCycle(1'b0, 1'b0);
        assert (validsSeen >= writesSeen) else begin
            $display("words were still missing when the drain timed out");
            stimErrors++;
        end
        waitDrained("after the drain");
        reportTest("drain to empty", startErrors);

        $display("%0d words checked, %0d errors", wordsChecked, stimErrors + compareErrors);
        if (stimErrors + compareErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
common/fifoCfgPkg.sv
common/eccPkg.sv
common/memReadIf.sv
fifo/delayPipe.sv
fifo/fifoController.sv
fifo/fifoMemory.sv
hw/fastFifo.sv
tests/clockGen.sv
tests/fastFifo_assert.sv
tests/fastFifoTb.sv

// File: Makefile
SRCS := tb.f $(wildcard common/*.sv fifo/*.sv hw/*.sv tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/fastFifoSim: $(SRCS)
	verilator --binary --assert --top-module fastFifoTb -f tb.f -Mdir obj_dir -o fastFifoSim

run: obj_dir/fastFifoSim
	obj_dir/fastFifoSim | tee sim.log
	@if grep -q "test failed" sim.log; then echo "simulation reported errors"; exit 1; fi
	@grep -q "test passed" sim.log || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir sim.log
